// File: rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int XLEN = 32; // shift amounts and funct7 decoding assume 32 bits.

    typedef logic [XLEN-1:0] word_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101; // SRL or SRA, picked by funct7 or imm.
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        MEM_WAIT,
        DONE
    } ctrl_state_e;

endpackage

// File: mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if
    import rv_exec_pkg::*;
();

    logic  req;
    logic  we;
    word_t addr;  // byte address, only whole words are served.
    word_t wdata;
    word_t rdata;
    logic  ready; // one-cycle pulse, rdata is valid with it.

    modport master (output req, we, addr, wdata, input rdata, ready);
    modport slave  (input req, we, addr, wdata, output rdata, ready);

endinterface

// File: mem_wait_counter.sv
`timescale 1ns/1ns

module mem_wait_counter #(
    parameter int LATENCY = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic busy,
    output logic done
);

    localparam int CNT_W = $clog2(LATENCY + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(LATENCY);
        end else if (count != '0) begin
            count <= count - CNT_W'(1);
        end
    end

    assign busy = (count != '0);
    assign done = (count == CNT_W'(1)); // last cycle of the wait.

endmodule

// File: data_mem.sv
`timescale 1ns/1ns

module data_mem
    import rv_exec_pkg::*;
#(
    parameter int DEPTH   = 64,
    parameter int LATENCY = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave bus
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t            mem [DEPTH];
    logic [IDX_W-1:0] word_idx;
    logic             start;
    logic             busy;
    logic             done;

    assign word_idx = IDX_W'((bus.addr >> 2) % DEPTH);

    // the ready term keeps a request that is still high from restarting the wait.
    assign start = bus.req && !busy && !bus.ready;

    mem_wait_counter #(
        .LATENCY (LATENCY)
    ) u_wait (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .busy  (busy),
        .done  (done)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            bus.ready <= 1'b0;
            bus.rdata <= '0;
        end else begin
            bus.ready <= done;
            if (done) begin
                bus.rdata <= mem[word_idx]; // a store returns the old word.
                if (bus.we) begin
                    mem[word_idx] <= bus.wdata;
                end
            end
        end
    end

endmodule

// File: int_alu.sv
`timescale 1ns/1ns

module int_alu
    import rv_exec_pkg::*;
(
    input  opcode_e op,
    input  funct3_t funct3,
    input  funct7_t funct7,
    input  word_t   pc_in,
    input  word_t   rs1,
    input  word_t   rs2,
    input  word_t   imm,
    output word_t   result
);

    word_t      op_b;
    word_t      alu_out;
    logic [4:0] shamt;
    logic       sub_sel;
    logic       sra_sel;
    logic       slt;
    logic       sltu;

    assign op_b    = (op == OP_REG) ? rs2 : imm;
    assign shamt   = op_b[4:0];
    assign sub_sel = (op == OP_REG) && funct7[5]; // OP-IMM has no subtract.
    assign sra_sel = (op == OP_REG) ? funct7[5] : imm[10];
    assign slt     = $signed(rs1) < $signed(op_b);
    assign sltu    = rs1 < op_b;

    always_comb begin
        case (funct3)
            F3_ADD:  alu_out = sub_sel ? (rs1 - op_b) : (rs1 + op_b);
            F3_SLL:  alu_out = rs1 << shamt;
            F3_SLT:  alu_out = {{(XLEN-1){1'b0}}, slt};
            F3_SLTU: alu_out = {{(XLEN-1){1'b0}}, sltu};
            F3_XOR:  alu_out = rs1 ^ op_b;
            F3_SR:   alu_out = sra_sel ? word_t'($signed(rs1) >>> shamt) : (rs1 >> shamt);
            F3_OR:   alu_out = rs1 | op_b;
            F3_AND:  alu_out = rs1 & op_b;
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_LUI:   result = imm; // the decoder has already shifted the immediate.
            OP_AUIPC: result = pc_in + imm;
            default:  result = alu_out;
        endcase
    end

endmodule

// File: branch_unit.sv
`timescale 1ns/1ns

module branch_unit
    import rv_exec_pkg::*;
(
    input  opcode_e op,
    input  funct3_t funct3,
    input  word_t   pc_in,
    input  word_t   rs1,
    input  word_t   rs2,
    input  word_t   imm,
    output word_t   next_pc,
    output word_t   link_value,
    output logic    taken
);

    word_t jalr_sum;
    logic  cond;

    assign jalr_sum   = rs1 + imm;
    assign link_value = pc_in + 32'd4;

    always_comb begin
        case (funct3)
            F3_BEQ:  cond = (rs1 == rs2);
            F3_BNE:  cond = (rs1 != rs2);
            F3_BLT:  cond = $signed(rs1) < $signed(rs2);
            F3_BGE:  cond = $signed(rs1) >= $signed(rs2);
            F3_BLTU: cond = rs1 < rs2;
            F3_BGEU: cond = rs1 >= rs2;
            default: cond = 1'b0; // funct3 2 and 3 are not branches.
        endcase
    end

    always_comb begin
        case (op)
            OP_JAL:    next_pc = pc_in + imm;
            OP_JALR:   next_pc = {jalr_sum[XLEN-1:1], 1'b0};
            OP_BRANCH: next_pc = cond ? (pc_in + imm) : link_value;
            default:   next_pc = link_value;
        endcase
    end

    assign taken = (op == OP_JAL) || (op == OP_JALR) || ((op == OP_BRANCH) && cond);

endmodule

// File: exec_ctrl.sv
`timescale 1ns/1ns

module exec_ctrl
    import rv_exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en,
    input  opcode_e   op,
    input  word_t     rs1,
    input  word_t     rs2,
    input  word_t     imm,
    input  word_t     alu_result,
    input  word_t     next_pc,
    input  word_t     link_value,
    input  logic      taken,
    output word_t     pc_out,
    output word_t     val_out,
    output logic      flush_pipeline,
    output logic      ready,
    mem_bus_if.master bus
);

    ctrl_state_e state;
    logic        is_mem;
    word_t       mem_addr;

    assign is_mem   = (op == OP_LOAD) || (op == OP_STORE);
    assign mem_addr = rs1 + imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= IDLE;
            ready          <= 1'b0;
            flush_pipeline <= 1'b0;
            bus.req        <= 1'b0;
            bus.we         <= 1'b0;
            val_out        <= '0;
            pc_out         <= '0;
        end else if (!en) begin
            state          <= IDLE; // dropping en ends the instruction.
            ready          <= 1'b0;
            flush_pipeline <= 1'b0;
            bus.req        <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (is_mem) begin
                        bus.req <= 1'b1;
                        bus.we  <= (op == OP_STORE);
                        state   <= MEM_WAIT;
                    end else begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (op == OP_JAL || op == OP_JALR) begin
                        val_out <= link_value;
                    end else if (op != OP_BRANCH) begin
                        val_out <= alu_result; // branches keep the old value.
                    end
                    pc_out         <= next_pc;
                    flush_pipeline <= taken;
                    state          <= DONE;
                end
                MEM_WAIT: begin
                    if (bus.ready) begin
                        bus.req <= 1'b0;
                        if (op == OP_LOAD) begin
                            val_out <= bus.rdata;
                        end
                        pc_out <= next_pc; // pc plus 4 for loads and stores.
                        state  <= DONE;
                    end
                end
                DONE: begin
                    ready <= 1'b1; // held until en falls.
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // address and store data are latched once and held for the whole request.
    always_ff @(posedge clk) begin
        if (state == IDLE && en && is_mem) begin
            bus.addr  <= mem_addr;
            bus.wdata <= rs2;
        end
    end

endmodule

// File: exec_top.sv
`timescale 1ns/1ns

module exec_top
    import rv_exec_pkg::*;
#(
    parameter int MEM_DEPTH   = 64,
    parameter int MEM_LATENCY = 2
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    en,
    input  opcode_e op,
    input  funct3_t funct3,
    input  funct7_t funct7,
    input  word_t   pc_in,
    input  word_t   rs1,
    input  word_t   rs2,
    input  word_t   imm,
    output word_t   pc_out,
    output word_t   val_out,
    output logic    flush_pipeline,
    output logic    ready
);

    word_t alu_result;
    word_t next_pc;
    word_t link_value;
    logic  taken;

    mem_bus_if mem_bus ();

    int_alu u_alu (
        .op     (op),
        .funct3 (funct3),
        .funct7 (funct7),
        .pc_in  (pc_in),
        .rs1    (rs1),
        .rs2    (rs2),
        .imm    (imm),
        .result (alu_result)
    );

    branch_unit u_branch (
        .op         (op),
        .funct3     (funct3),
        .pc_in      (pc_in),
        .rs1        (rs1),
        .rs2        (rs2),
        .imm        (imm),
        .next_pc    (next_pc),
        .link_value (link_value),
        .taken      (taken)
    );

    exec_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .op             (op),
        .rs1            (rs1),
        .rs2            (rs2),
        .imm            (imm),
        .alu_result     (alu_result),
        .next_pc        (next_pc),
        .link_value     (link_value),
        .taken          (taken),
        .pc_out         (pc_out),
        .val_out        (val_out),
        .flush_pipeline (flush_pipeline),
        .ready          (ready),
        .bus            (mem_bus.master)
    );

    data_mem #(
        .DEPTH   (MEM_DEPTH),
        .LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mem_bus.slave)
    );

endmodule

// File: tb_exec_top.sv
`timescale 1ns/1ns

module tb_exec_top
    import rv_exec_pkg::*;
();

    localparam int    MEM_LATENCY = 2;
    localparam word_t ALU_PC      = 32'h0000_0100;
    localparam word_t BR_PC       = 32'h0000_0400;
    localparam word_t BR_OFF      = 32'h0000_0080;
    localparam word_t MEM_PC      = 32'h0000_0500;

    typedef struct {
        string   name;
        opcode_e op;
        funct3_t funct3;
        funct7_t funct7;
        word_t   pc;
        word_t   rs1;
        word_t   rs2;
        word_t   imm;
        word_t   exp_val;
        word_t   exp_pc;
        logic    exp_flush;
        logic    skip_val; // branches and stores leave val_out alone.
    } row_t;

    logic    clk;
    logic    rst_n;
    logic    en;
    opcode_e op;
    funct3_t funct3;
    funct7_t funct7;
    word_t   pc_in;
    word_t   rs1;
    word_t   rs2;
    word_t   imm;
    word_t   pc_out;
    word_t   val_out;
    logic    flush_pipeline;
    logic    ready;

    row_t    rows[$];
    integer  seed;

    exec_top #(
        .MEM_DEPTH   (64),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_exec_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .op             (op),
        .funct3         (funct3),
        .funct7         (funct7),
        .pc_in          (pc_in),
        .rs1            (rs1),
        .rs2            (rs2),
        .imm            (imm),
        .pc_out         (pc_out),
        .val_out        (val_out),
        .flush_pipeline (flush_pipeline),
        .ready          (ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // counts falling edges until ready has the wanted level.
    task automatic wait_ready(input logic level, input int limit, input string what,
                              output int cycles);
        int count;
        count = 0;
        do begin
            @(negedge clk);
            count++;
            if (count > limit) begin
                $display("timeout: ready never went to %0b within %0d cycles in %s",
                         level, limit, what);
                $display("SOME TESTS FAILED");
                $fatal(1, "wait for ready timed out");
            end
        end while (ready !== level);
        cycles = count;
    endtask

    function automatic void add_row(input string name, input opcode_e o, input funct3_t f3,
                                    input funct7_t f7, input word_t pc, input word_t a,
                                    input word_t b, input word_t im, input word_t val,
                                    input word_t npc, input logic fl, input logic skip);
        row_t r;
        r = '{name, o, f3, f7, pc, a, b, im, val, npc, fl, skip};
        rows.push_back(r);
    endfunction

    function automatic void alu_row(input string name, input opcode_e o, input funct3_t f3,
                                    input funct7_t f7, input word_t a, input word_t b,
                                    input word_t im, input word_t val);
        add_row(name, o, f3, f7, ALU_PC, a, b, im, val, ALU_PC + 4, 1'b0, 1'b0);
    endfunction

    function automatic void branch_row(input string name, input funct3_t f3, input word_t a,
                                       input word_t b, input logic is_taken);
        add_row(name, OP_BRANCH, f3, 7'h00, BR_PC, a, b, BR_OFF, '0,
                is_taken ? BR_PC + BR_OFF : BR_PC + 4, is_taken, 1'b1);
    endfunction

    function automatic void mem_row(input string name, input opcode_e o, input word_t base,
                                    input word_t data, input word_t off, input word_t val);
        add_row(name, o, 3'b010, 7'h00, MEM_PC, base, data, off, val, MEM_PC + 4, 1'b0,
                o == OP_STORE);
    endfunction

    function automatic word_t expected_reg_op(input funct3_t f3, input word_t a, input word_t b);
        if (f3 == F3_ADD) begin
            return a + b;
        end else if (f3 == F3_XOR) begin
            return a ^ b;
        end
        return (a < b) ? 32'd1 : 32'd0; // unsigned compare.
    endfunction

    function automatic void build_table();
        alu_row("add", OP_REG, F3_ADD, 7'h00, 5, 7, 0, 12);
        alu_row("sub", OP_REG, F3_ADD, 7'h20, 5, 7, 0, 32'hffff_fffe);
        alu_row("addi_neg", OP_IMM, F3_ADD, 7'h7f, 10, 0, 32'hffff_ffff, 9);
        alu_row("sll", OP_REG, F3_SLL, 7'h00, 1, 32'h24, 0, 32'h10);
        alu_row("slt_neg", OP_REG, F3_SLT, 7'h00, 32'hffff_fff0, 3, 0, 1);
        alu_row("sltu_neg", OP_REG, F3_SLTU, 7'h00, 32'hffff_fff0, 3, 0, 0);
        alu_row("slti", OP_IMM, F3_SLT, 7'h00, 5, 0, 32'hffff_ffff, 0);
        alu_row("sltiu", OP_IMM, F3_SLTU, 7'h00, 5, 0, 32'hffff_ffff, 1);
        alu_row("xori", OP_IMM, F3_XOR, 7'h00, 32'hf0f0_f0f0, 0, 32'h0000_ffff, 32'hf0f0_0f0f);
        alu_row("srl", OP_REG, F3_SR, 7'h00, 32'h8000_0000, 4, 0, 32'h0800_0000);
        alu_row("sra", OP_REG, F3_SR, 7'h20, 32'h8000_0000, 4, 0, 32'hf800_0000);
        alu_row("srai", OP_IMM, F3_SR, 7'h00, 32'h8000_0000, 0, 32'h404, 32'hf800_0000);
        alu_row("ori", OP_IMM, F3_OR, 7'h00, 32'h1234_0000, 0, 32'h5678, 32'h1234_5678);
        alu_row("and", OP_REG, F3_AND, 7'h00, 32'hff00_ff00, 32'h0ff0_0ff0, 0, 32'h0f00_0f00);
        add_row("lui", OP_LUI, 3'b000, 7'h00, 32'h200, 0, 0, 32'h1234_5000, 32'h1234_5000,
                32'h204, 1'b0, 1'b0);
        add_row("auipc", OP_AUIPC, 3'b000, 7'h00, 32'h200, 0, 0, 32'h1000, 32'h1200,
                32'h204, 1'b0, 1'b0);
        add_row("jal", OP_JAL, 3'b000, 7'h00, 32'h300, 0, 0, 32'h40, 32'h304, 32'h340,
                1'b1, 1'b0);
        add_row("jalr_odd", OP_JALR, 3'b000, 7'h00, 32'h300, 32'h1000, 0, 32'h21, 32'h304,
                32'h1020, 1'b1, 1'b0); // bit 0 of the sum is cleared.
        branch_row("beq_t", F3_BEQ, 7, 7, 1'b1);
        branch_row("beq_n", F3_BEQ, 7, 8, 1'b0);
        branch_row("bne_t", F3_BNE, 7, 8, 1'b1);
        branch_row("bne_n", F3_BNE, 7, 7, 1'b0);
        branch_row("blt_t", F3_BLT, 32'hffff_ffff, 1, 1'b1);
        branch_row("blt_n", F3_BLT, 1, 32'hffff_ffff, 1'b0);
        branch_row("bge_t", F3_BGE, 1, 32'hffff_ffff, 1'b1);
        branch_row("bge_n", F3_BGE, 32'hffff_ffff, 1, 1'b0);
        branch_row("bltu_t", F3_BLTU, 1, 32'hffff_ffff, 1'b1);
        branch_row("bltu_n", F3_BLTU, 32'hffff_ffff, 1, 1'b0);
        branch_row("bgeu_t", F3_BGEU, 32'hffff_ffff, 1, 1'b1);
        branch_row("bgeu_n", F3_BGEU, 1, 32'hffff_ffff, 1'b0);
        mem_row("sw_a", OP_STORE, 32'h10, 32'hdead_beef, 0, 0);
        mem_row("sw_b", OP_STORE, 32'h20, 32'hcafe_f00d, 8, 0);
        mem_row("sw_c", OP_STORE, 32'h40, 32'h0bad_c0de, 32'hffff_fffc, 0);
        mem_row("lw_c", OP_LOAD, 32'h3c, 0, 0, 32'h0bad_c0de);
        mem_row("lw_a", OP_LOAD, 32'h08, 0, 8, 32'hdead_beef);
        mem_row("lw_b", OP_LOAD, 32'h28, 0, 0, 32'hcafe_f00d);
        mem_row("lw_empty", OP_LOAD, 32'h80, 0, 4, 0);
    endfunction

    task automatic run_row(input row_t r);
        int cycles;
        @(posedge clk);
        op     <= r.op;
        funct3 <= r.funct3;
        funct7 <= r.funct7;
        pc_in  <= r.pc;
        rs1    <= r.rs1;
        rs2    <= r.rs2;
        imm    <= r.imm;
        en     <= 1'b1;
        wait_ready(1'b1, 50, r.name, cycles);
        if (!r.skip_val) begin
            check_value({r.name, " val"}, r.exp_val, val_out);
        end
        check_value({r.name, " pc"}, r.exp_pc, pc_out);
        check_value({r.name, " flush"}, {31'b0, r.exp_flush}, {31'b0, flush_pipeline});
        @(posedge clk);
        en <= 1'b0;
        wait_ready(1'b0, 10, r.name, cycles);
        // the drop is sampled on the edge after the one that drives it.
        check_value({r.name, " ready fall"}, 32'd2, word_t'(cycles));
        check_value({r.name, " flush low"}, 32'd0, {31'b0, flush_pipeline});
    endtask

    initial begin
        word_t   a;
        word_t   b;
        funct3_t sel;
        rst_n  <= 1'b0;
        en     <= 1'b0;
        op     <= OP_IMM;
        funct3 <= '0;
        funct7 <= '0;
        pc_in  <= '0;
        rs1    <= '0;
        rs2    <= '0;
        imm    <= '0;
        seed = 69;
        build_table();
        for (int i = 0; i < 20; i++) begin
            a = $random(seed);
            b = $random(seed);
            sel = (i % 3 == 0) ? F3_ADD : ((i % 3 == 1) ? F3_XOR : F3_SLTU);
            add_row($sformatf("rand_%0d", i), OP_REG, sel, 7'h00, 32'h600 + 4 * i, a, b, 0,
                    expected_reg_op(sel, a, b), 32'h604 + 4 * i, 1'b0, 1'b0);
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset ready", 32'd0, {31'b0, ready});
        check_value("reset flush", 32'd0, {31'b0, flush_pipeline});
        check_value("reset val", 32'd0, val_out);
        check_value("reset pc", 32'd0, pc_out);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
rv_exec_pkg.sv
mem_bus_if.sv
mem_wait_counter.sv
data_mem.sv
int_alu.sv
branch_unit.sv
exec_ctrl.sv
exec_top.sv
tb_exec_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_top
FILES     ?= vlog.f
VFLAGS    ?= --timing
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

# Lint the whole project from the testbench top down.
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILES) --top-module $(TOP)

# Build and run; a $fatal in the testbench gives a nonzero exit status.
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILES) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
